// ==== rtl/zynq_shell_consts.svh ====
`ifndef ZYNQ_SHELL_CONSTS_SVH
`define ZYNQ_SHELL_CONSTS_SVH

// host register word and host side addressing
`define ZS_CSR_WIDTH 32
`define ZS_HOST_ADDR_WIDTH 32
// the core physical space is wider than anything the host can see
`define ZS_CORE_ADDR_WIDTH 40
`define ZS_DRAM_ADDR_WIDTH 32
// core DRAM starts here, the remap strips it off with an xor
`define ZS_DRAM_BASE 32'h8000_0000
// one sticky bit per 8 MB region of core DRAM
`define ZS_PROF_BITS 128
`define ZS_FIFO_DEPTH 8

// host register map, the profiler occupies four slots from PROF0
`define ZS_IDX_WIDTH 4
`define ZS_IDX_RESET 0
`define ZS_IDX_ALLOC 1
`define ZS_IDX_BASE 2
`define ZS_IDX_CORE_RESET 3
`define ZS_IDX_PROF0 4
`define ZS_IDX_FIFO 8

`endif

// ==== rtl/zynq_shell_pkg.sv ====
`include "zynq_shell_consts.svh"

package zynq_shell_pkg;

   // layout of one core I/O write as the host sees it
   // valid sits on top so the host can tell a real entry from an empty read
   typedef struct packed
   {
      logic        valid;
      logic [22:0] addr;
      logic [7:0]  data;
   } io_fifo_fields_s;

   // the packer fills in fields while the host only ever wants the raw word
   typedef union packed
   {
      io_fifo_fields_s             fields;
      logic [`ZS_CSR_WIDTH-1:0]    raw;
   } io_fifo_word_u;

endpackage

// ==== rtl/io_fifo_if.sv ====
`timescale 1ns/1ns

interface io_fifo_if;

   // push side, a word moves when push_v and push_ready meet on an edge
   zynq_shell_pkg::io_fifo_word_u push_data;
   logic                          push_v;
   logic                          push_ready;

   // pop side, pop_yumi is only raised while pop_v is high
   zynq_shell_pkg::io_fifo_word_u pop_data;
   logic                          pop_v;
   logic                          pop_yumi;

   modport producer (output push_data, output push_v, input push_ready);

   modport buffer (input push_data, input push_v, output push_ready,
                   output pop_data, output pop_v, input pop_yumi);

   modport consumer (input pop_data, input pop_v, output pop_yumi);

endinterface

// ==== rtl/io_write_packer.sv ====
`timescale 1ns/1ns

module io_write_packer
   (
    input  logic        io_req_i
    ,input  logic        io_we_i
    ,input  logic [22:0] io_addr_i
    ,input  logic [7:0]  io_data_i
    ,output logic        io_ready_o
    ,io_fifo_if.producer fifo
    );

   logic io_write;

   // only writes are forwarded, I/O reads never reach the host
   assign io_write = io_req_i & io_we_i;

   // the valid flag travels inside the word as well as on push_v
   assign fifo.push_data.fields.valid = io_write;
   assign fifo.push_data.fields.addr  = io_addr_i;
   assign fifo.push_data.fields.data  = io_data_i;
   assign fifo.push_v                 = io_write;

   // the core sees FIFO back-pressure directly and must hold off
   // while this is low, anything it offers is lost
   assign io_ready_o = fifo.push_ready;

endmodule

// ==== rtl/io_fifo.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module io_fifo
   #(parameter int DEPTH = `ZS_FIFO_DEPTH)
   (
    input  logic       clk_i
    ,input  logic       reset_i
    ,io_fifo_if.buffer  fifo
    );

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   zynq_shell_pkg::io_fifo_word_u mem_r [DEPTH];
   logic [PTR_W-1:0]              wr_ptr_r;
   logic [PTR_W-1:0]              rd_ptr_r;
   logic [CNT_W-1:0]              count_r;
   logic                          full;
   logic                          empty;
   logic                          push;
   logic                          pop;

   // pointers wrap explicitly so depths that are not a power of two work
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full  = (count_r == CNT_W'(DEPTH));
   assign empty = (count_r == '0);

   // a pop in the same cycle frees the head slot, so a full FIFO can still take a word
   assign fifo.push_ready = ~full | fifo.pop_yumi;
   assign fifo.pop_v      = ~empty;
   assign fifo.pop_data   = mem_r[rd_ptr_r];

   assign push = fifo.push_v & fifo.push_ready;
   assign pop  = fifo.pop_yumi & ~empty;

   // storage holds payload only, occupancy is tracked by the count
   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_r[wr_ptr_r] <= fifo.push_data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr_r <= ptr_next(wr_ptr_r);
         end
         if (pop)
         begin
            rd_ptr_r <= ptr_next(rd_ptr_r);
         end
         // push and pop together leave the count unchanged
         count_r <= count_r + CNT_W'(push) - CNT_W'(pop);
      end
   end

endmodule

// ==== rtl/host_csr_file.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module host_csr_file
   (
    input  logic                      clk_i
    ,input  logic                      reset_i
    ,input  logic                      host_we_i
    ,input  logic [`ZS_IDX_WIDTH-1:0]  host_widx_i
    ,input  logic [`ZS_CSR_WIDTH-1:0]  host_wdata_i
    ,input  logic                      host_re_i
    ,input  logic [`ZS_IDX_WIDTH-1:0]  host_ridx_i
    ,output logic [`ZS_CSR_WIDTH-1:0]  host_rdata_o
    ,output logic                      host_rvalid_o
    ,input  logic [`ZS_PROF_BITS-1:0]  prof_i
    ,output logic [`ZS_CSR_WIDTH-1:0]  dram_base_o
    ,output logic                      bp_reset_o
    ,output logic                      core_reset_o
    ,io_fifo_if.consumer               fifo
    );

   // the four host writable control words, indexed directly by the low index bits
   logic [3:0][`ZS_CSR_WIDTH-1:0] csr_r;
   // profiler seen as four host words, low word first
   logic [3:0][`ZS_CSR_WIDTH-1:0] prof_words;
   logic [`ZS_CSR_WIDTH-1:0]      rdata_n;
   logic                          fifo_rd;

   assign prof_words = prof_i;

   // the host releases each reset by writing a one into bit 0
   // so both resets stay asserted from power up until software says otherwise
   assign bp_reset_o   = reset_i | ~csr_r[`ZS_IDX_RESET][0];
   assign core_reset_o = reset_i | ~csr_r[`ZS_IDX_CORE_RESET][0];
   assign dram_base_o  = csr_r[`ZS_IDX_BASE];

   // a read of the FIFO slot consumes the head, but only if there is one
   assign fifo_rd       = host_re_i & (host_ridx_i == `ZS_IDX_FIFO);
   assign fifo.pop_yumi = fifo_rd & fifo.pop_v;

   // read select, unmapped slots and an empty FIFO both read as zero
   always_comb
   begin
      rdata_n = '0;
      if (host_ridx_i <= `ZS_IDX_CORE_RESET)
      begin
         rdata_n = csr_r[host_ridx_i[1:0]];
      end
      else if (host_ridx_i < `ZS_IDX_PROF0 + 4)
      begin
         rdata_n = prof_words[host_ridx_i[1:0]];
      end
      else if (fifo_rd && fifo.pop_v)
      begin
         rdata_n = fifo.pop_data.raw;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         csr_r         <= '0;
         host_rvalid_o <= 1'b0;
      end
      else
      begin
         // one valid pulse per read, so reads can be issued back to back
         host_rvalid_o <= host_re_i;
         if (host_we_i)
         begin
            case (host_widx_i)
               `ZS_IDX_RESET, `ZS_IDX_ALLOC, `ZS_IDX_BASE, `ZS_IDX_CORE_RESET:
                  csr_r[host_widx_i[1:0]] <= host_wdata_i;
               default:
                  csr_r <= csr_r;
            endcase
         end
      end
   end

   // read data is only meaningful alongside host_rvalid_o
   always_ff @(posedge clk_i)
   begin
      if (host_re_i)
      begin
         host_rdata_o <= rdata_n;
      end
   end

endmodule

// ==== rtl/mem_addr_xlate.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module mem_addr_xlate
   (
    input  logic                            clk_i
    ,input  logic [`ZS_HOST_ADDR_WIDTH-1:0]  host_addr_i
    ,output logic [`ZS_CORE_ADDR_WIDTH-1:0]  core_addr_o
    ,input  logic                            core_mem_v_i
    ,input  logic [`ZS_DRAM_ADDR_WIDTH-1:0]  core_mem_addr_i
    ,output logic                            ps_mem_v_o
    ,output logic [`ZS_DRAM_ADDR_WIDTH-1:0]  ps_mem_addr_o
    ,input  logic [`ZS_CSR_WIDTH-1:0]        dram_base_i
    ,input  logic                            prof_clear_i
    ,output logic [`ZS_PROF_BITS-1:0]        prof_o
    );

   localparam int PROF_IDX_W = $clog2(`ZS_PROF_BITS);

   logic [PROF_IDX_W-1:0] prof_idx;

   // the host sees two 256 MB windows and bit 29 picks one
   // bit 29 clear lands in core DRAM at 0x8000_0000 and up
   // bit 29 set lands in the core's local space starting at zero
   assign core_addr_o = {{(`ZS_CORE_ADDR_WIDTH - 32){1'b0}},
                         ~host_addr_i[29],
                         3'b000,
                         host_addr_i[27:0]};

   // core DRAM addresses carry the 0x8000_0000 base, xor removes it
   // and the host allocated physical base is then added on
   assign ps_mem_addr_o = (core_mem_addr_i ^ `ZS_DRAM_BASE) + dram_base_i;
   assign ps_mem_v_o    = core_mem_v_i;

   // each profiler bit covers one 8 MB slice of the low 1 GB
   assign prof_idx = core_mem_addr_i[29:23];

   // the bits are sticky until the core complex goes back into reset
   // which also covers the global reset
   always_ff @(posedge clk_i)
   begin
      if (prof_clear_i)
      begin
         prof_o <= '0;
      end
      else if (core_mem_v_i)
      begin
         prof_o[prof_idx] <= 1'b1;
      end
   end

endmodule

// ==== rtl/zynq_shell_top.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module zynq_shell_top
   (
    input  logic                            clk_i
    ,input  logic                            reset_i
    // host register port
    ,input  logic                            host_we_i
    ,input  logic [`ZS_IDX_WIDTH-1:0]        host_widx_i
    ,input  logic [`ZS_CSR_WIDTH-1:0]        host_wdata_i
    ,input  logic                            host_re_i
    ,input  logic [`ZS_IDX_WIDTH-1:0]        host_ridx_i
    ,output logic [`ZS_CSR_WIDTH-1:0]        host_rdata_o
    ,output logic                            host_rvalid_o
    // host window into the core
    ,input  logic [`ZS_HOST_ADDR_WIDTH-1:0]  host_addr_i
    ,output logic [`ZS_CORE_ADDR_WIDTH-1:0]  core_addr_o
    // core DRAM requests toward the PS
    ,input  logic                            core_mem_v_i
    ,input  logic [`ZS_DRAM_ADDR_WIDTH-1:0]  core_mem_addr_i
    ,output logic                            ps_mem_v_o
    ,output logic [`ZS_DRAM_ADDR_WIDTH-1:0]  ps_mem_addr_o
    ,output logic                            bp_reset_o
    ,output logic                            core_reset_o
    // core I/O writes toward the host
    ,input  logic                            io_req_i
    ,input  logic                            io_we_i
    ,input  logic [22:0]                     io_addr_i
    ,input  logic [7:0]                      io_data_i
    ,output logic                            io_ready_o
    );

   logic [`ZS_CSR_WIDTH-1:0] dram_base;
   logic [`ZS_PROF_BITS-1:0] prof;

   io_fifo_if fifo_if ();

   io_write_packer i_packer
      (.io_req_i   (io_req_i)
       ,.io_we_i    (io_we_i)
       ,.io_addr_i  (io_addr_i)
       ,.io_data_i  (io_data_i)
       ,.io_ready_o (io_ready_o)
       ,.fifo       (fifo_if.producer)
       );

   io_fifo #(.DEPTH(`ZS_FIFO_DEPTH)) i_fifo
      (.clk_i    (clk_i)
       ,.reset_i (reset_i)
       ,.fifo    (fifo_if.buffer)
       );

   // the core complex reset also clears the profiler, so it is fed back in below
   host_csr_file i_csr
      (.clk_i          (clk_i)
       ,.reset_i       (reset_i)
       ,.host_we_i     (host_we_i)
       ,.host_widx_i   (host_widx_i)
       ,.host_wdata_i  (host_wdata_i)
       ,.host_re_i     (host_re_i)
       ,.host_ridx_i   (host_ridx_i)
       ,.host_rdata_o  (host_rdata_o)
       ,.host_rvalid_o (host_rvalid_o)
       ,.prof_i        (prof)
       ,.dram_base_o   (dram_base)
       ,.bp_reset_o    (bp_reset_o)
       ,.core_reset_o  (core_reset_o)
       ,.fifo          (fifo_if.consumer)
       );

   mem_addr_xlate i_xlate
      (.clk_i            (clk_i)
       ,.host_addr_i     (host_addr_i)
       ,.core_addr_o     (core_addr_o)
       ,.core_mem_v_i    (core_mem_v_i)
       ,.core_mem_addr_i (core_mem_addr_i)
       ,.ps_mem_v_o      (ps_mem_v_o)
       ,.ps_mem_addr_o   (ps_mem_addr_o)
       ,.dram_base_i     (dram_base)
       ,.prof_clear_i    (bp_reset_o)
       ,.prof_o          (prof)
       );

endmodule

// ==== testbench/zynq_shell_chk.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module zynq_shell_chk
   (
    input  logic                      clk_i
    ,input  logic                      reset_i
    ,input  logic                      host_re_i
    ,input  logic [`ZS_IDX_WIDTH-1:0]  host_ridx_i
    ,input  logic                      host_rvalid_o
    ,input  logic                      core_mem_v_i
    ,input  logic                      ps_mem_v_o
    ,input  logic                      bp_reset_o
    ,input  logic                      core_reset_o
    ,input  logic                      io_req_i
    ,input  logic                      io_we_i
    ,input  logic                      io_ready_o
    );

   logic fifo_read;
   int   fail_count = 0;

   // a FIFO read is the only thing that frees a slot in a full FIFO
   assign fifo_read = host_re_i & (host_ridx_i == `ZS_IDX_FIFO);

   a_rvalid_delay: assert property (@(posedge clk_i) disable iff (reset_i)
      host_rvalid_o == $past(host_re_i))
   else
   begin
      fail_count++;
      $error("host_rvalid_o is not host_re_i delayed by one cycle");
   end

   a_ps_valid: assert property (@(posedge clk_i) ps_mem_v_o == core_mem_v_i)
   else
   begin
      fail_count++;
      $error("ps_mem_v_o differs from core_mem_v_i");
   end

   a_reset_out: assert property (@(posedge clk_i) reset_i |-> bp_reset_o && core_reset_o)
   else
   begin
      fail_count++;
      $error("a reset output is low during reset_i");
   end

   // a dropped write leaves the FIFO full, so only a pop in the next cycle raises io_ready_o
   a_write_drop: assert property (@(posedge clk_i) disable iff (reset_i)
      (!io_ready_o && io_req_i && io_we_i && !fifo_read) |=> (!io_ready_o || fifo_read))
   else
   begin
      fail_count++;
      $error("an I/O write was taken while io_ready_o was low");
   end

endmodule

// ==== testbench/zynq_shell_tb.sv ====
`timescale 1ns/1ns
`include "zynq_shell_consts.svh"

module zynq_shell_tb;

   // three hex words per operation in the pattern file
   localparam int PAT_WORDS  = 192;
   localparam int WAIT_LIMIT = 16;

   logic        clk_i;
   logic        reset_i;
   logic        host_we_i;
   logic [3:0]  host_widx_i;
   logic [31:0] host_wdata_i;
   logic        host_re_i;
   logic [3:0]  host_ridx_i;
   logic [31:0] host_rdata_o;
   logic        host_rvalid_o;
   logic [31:0] host_addr_i;
   logic [39:0] core_addr_o;
   logic        core_mem_v_i;
   logic [31:0] core_mem_addr_i;
   logic        ps_mem_v_o;
   logic [31:0] ps_mem_addr_o;
   logic        bp_reset_o;
   logic        core_reset_o;
   logic        io_req_i;
   logic        io_we_i;
   logic [22:0] io_addr_i;
   logic [7:0]  io_data_i;
   logic        io_ready_o;

   logic [39:0] pat_mem [PAT_WORDS];
   logic [31:0] lcg_state;
   // words the FIFO should hand back after a random burst, oldest first
   logic [31:0] exp_q [$];
   int          errors;
   int          test_errors;
   int          tests;

   zynq_shell_top i_dut (.*);

   bind zynq_shell_top zynq_shell_chk i_chk (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // valid on top, then the 23 address bits, then the data byte
   function automatic logic [31:0] pack_io_word(input logic [22:0] addr, input logic [7:0] data);
      return {1'b1, addr, data};
   endfunction

   task automatic report_mismatch(input string name, input logic [39:0] got,
                                  input logic [39:0] exp);
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
      test_errors++;
   endtask

   task automatic host_write(input logic [3:0] idx, input logic [31:0] data);
      host_we_i    = 1'b1;
      host_widx_i  = idx;
      host_wdata_i = data;
      @(negedge clk_i);
      host_we_i = 1'b0;
   endtask

   task automatic host_read(input logic [3:0] idx, input logic [31:0] exp);
      int waited;
      waited      = 0;
      host_re_i   = 1'b1;
      host_ridx_i = idx;
      @(negedge clk_i);
      host_re_i = 1'b0;
      // the response is due one cycle after the request
      while (!host_rvalid_o && waited < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         waited++;
      end
      if (!host_rvalid_o)
      begin
         $display("read of index %0d got no response before the timeout", idx);
         errors++;
         test_errors++;
      end
      else if (host_rdata_o !== exp)
      begin
         report_mismatch("host_rdata_o", host_rdata_o, exp);
      end
   endtask

   task automatic window_check(input logic [31:0] addr, input logic [39:0] exp);
      host_addr_i = addr;
      @(negedge clk_i);
      if (core_addr_o !== exp)
      begin
         report_mismatch("core_addr_o", core_addr_o, exp);
      end
   endtask

   // the request stays up for one edge so the profiler records it once
   task automatic dram_request(input logic [31:0] addr, input logic [31:0] exp);
      core_mem_v_i    = 1'b1;
      core_mem_addr_i = addr;
      @(negedge clk_i);
      if (ps_mem_addr_o !== exp)
      begin
         report_mismatch("ps_mem_addr_o", ps_mem_addr_o, exp);
      end
      if (ps_mem_v_o !== 1'b1)
      begin
         report_mismatch("ps_mem_v_o", ps_mem_v_o, 1'b1);
      end
      core_mem_v_i = 1'b0;
   endtask

   task automatic io_write(input logic [22:0] addr, input logic [7:0] data);
      io_req_i  = 1'b1;
      io_we_i   = 1'b1;
      io_addr_i = addr;
      io_data_i = data;
      @(negedge clk_i);
      io_req_i = 1'b0;
      io_we_i  = 1'b0;
   endtask

   // back to back writes with random data, the FIFO keeps only what fits
   task automatic io_burst(input int count, input logic [22:0] base);
      logic [22:0] addr;
      logic [7:0]  data;
      logic        exp_ready;
      for (int i = 0; i < count; i++)
      begin
         lcg_state = lcg_next(lcg_state);
         data      = lcg_state[23:16];
         addr      = base + 23'(i);
         io_req_i  = 1'b1;
         io_we_i   = 1'b1;
         io_addr_i = addr;
         io_data_i = data;
         if (exp_q.size() < `ZS_FIFO_DEPTH)
         begin
            exp_q.push_back(pack_io_word(addr, data));
         end
         @(negedge clk_i);
      end
      io_req_i  = 1'b0;
      io_we_i   = 1'b0;
      exp_ready = (exp_q.size() < `ZS_FIFO_DEPTH);
      if (io_ready_o !== exp_ready)
      begin
         report_mismatch("io_ready_o", io_ready_o, exp_ready);
      end
   endtask

   // pops every predicted word in order and then expects the empty read of zero
   task automatic fifo_drain();
      logic [31:0] exp;
      while (exp_q.size() > 0)
      begin
         exp = exp_q.pop_front();
         host_read(`ZS_IDX_FIFO, exp);
      end
      host_read(`ZS_IDX_FIFO, 32'h0);
   endtask

   // levels packed as bp_reset, core_reset, io_ready from the top bit down
   task automatic level_check(input logic [2:0] exp);
      if (bp_reset_o !== exp[2])
      begin
         report_mismatch("bp_reset_o", bp_reset_o, exp[2]);
      end
      if (core_reset_o !== exp[1])
      begin
         report_mismatch("core_reset_o", core_reset_o, exp[1]);
      end
      if (io_ready_o !== exp[0])
      begin
         report_mismatch("io_ready_o", io_ready_o, exp[0]);
      end
   endtask

   task automatic finish_test(input int num);
      if (test_errors == 0)
      begin
         $display("test %0d done without mismatches", num);
      end
      else
      begin
         $display("test %0d done with %0d mismatches", num, test_errors);
      end
      tests++;
      test_errors = 0;
   endtask

   task automatic run_patterns();
      int          ptr;
      logic        done;
      logic [39:0] a;
      logic [39:0] b;
      ptr  = 0;
      done = 1'b0;
      while (!done && ptr + 2 < PAT_WORDS)
      begin
         a = pat_mem[ptr + 1];
         b = pat_mem[ptr + 2];
         case (pat_mem[ptr][3:0])
            4'h1: host_write(a[3:0], b[31:0]);
            4'h2: host_read(a[3:0], b[31:0]);
            4'h3: window_check(a[31:0], b);
            4'h4: dram_request(a[31:0], b[31:0]);
            4'h5: io_write(a[22:0], b[7:0]);
            4'h6: io_burst(int'(a[7:0]), b[22:0]);
            4'h7: fifo_drain();
            4'h8: level_check(a[2:0]);
            4'h9: finish_test(int'(a[7:0]));
            4'hf: done = 1'b1;
            default:
            begin
               $display("pattern word %0d holds an unknown operation", ptr);
               errors++;
               done = 1'b1;
            end
         endcase
         ptr += 3;
      end
      if (!done)
      begin
         $display("pattern file ended without a stop operation");
         errors++;
      end
   endtask

   initial
   begin
      reset_i         = 1'b1;
      host_we_i       = 1'b0;
      host_widx_i     = '0;
      host_wdata_i    = '0;
      host_re_i       = 1'b0;
      host_ridx_i     = '0;
      host_addr_i     = '0;
      core_mem_v_i    = 1'b0;
      core_mem_addr_i = '0;
      io_req_i        = 1'b0;
      io_we_i         = 1'b0;
      io_addr_i       = '0;
      io_data_i       = '0;
      lcg_state       = 32'd96167;
      errors          = 0;
      test_errors     = 0;
      tests           = 0;
      $readmemh("testbench/zynq_shell_patterns.txt", pat_mem);
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      run_patterns();
      errors += i_dut.i_chk.fail_count;
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== testbench/zynq_shell_patterns.txt ====
// columns op a b in hex, op 1 write idx data, 2 read idx expected, 3 host addr core addr
// 4 dram addr ps addr, 5 io addr data, 6 burst count addr, 7 drain, 8 levels, 9 end test, f stop
8 7 0
2 0 0
2 1 0
2 2 0
2 3 0
2 4 0
2 5 0
2 6 0
2 7 0
2 8 0
9 1 0
1 1 a5a5a5a5
1 2 10000000
1 0 1
8 3 0
1 3 1
8 1 0
2 0 1
2 1 a5a5a5a5
2 2 10000000
2 3 1
9 2 0
3 01234567 0081234567
3 2abcdef0 000abcdef0
3 f0000010 0000000010
3 dfffffff 008fffffff
9 3 0
4 80000000 10000000
4 80800000 10800000
4 9fc00040 2fc00040
4 b0000000 40000000
9 4 0
2 4 3
2 5 80000000
2 6 0
2 7 1
1 0 0
1 0 1
2 4 0
2 5 0
2 6 0
2 7 0
9 5 0
5 12345 a5
5 7fffff 3c
2 8 812345a5
2 8 ffffff3c
2 8 0
6 a 100
7 0 0
9 6 0
f 0 0

// ==== verilog.f ====
+incdir+rtl
rtl/zynq_shell_pkg.sv
rtl/io_fifo_if.sv
rtl/io_write_packer.sv
rtl/io_fifo.sv
rtl/host_csr_file.sv
rtl/mem_addr_xlate.sv
rtl/zynq_shell_top.sv
testbench/zynq_shell_chk.sv
testbench/zynq_shell_tb.sv

// ==== Bender.yml ====
package:
  name: zynq_shell

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/zynq_shell_pkg.sv
      - rtl/io_fifo_if.sv
      - rtl/io_write_packer.sv
      - rtl/io_fifo.sv
      - rtl/host_csr_file.sv
      - rtl/mem_addr_xlate.sv
      - rtl/zynq_shell_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/zynq_shell_chk.sv
      - testbench/zynq_shell_tb.sv
